//--- verilog/lsu_pkg.sv
package lsu_pkg;

  // load/store opcodes from the execute stage
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } lsu_op_e;

  // controller FSM states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    LOOKUP   = 3'd1,
    BUS_REQ  = 3'd2,
    BUS_WAIT = 3'd3,
    RESP     = 3'd4,
    RELEASE  = 3'd5
  } lsu_state_e;

  // request from the core side
  typedef struct packed {
    lsu_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_req_t;

  // response back to the core
  typedef struct packed {
    logic [31:0] rdata;
  } lsu_rsp_t;

  // word-wide bus request, data already in its byte lanes
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  function automatic logic is_load(lsu_op_e op);
    return (op == LB) || (op == LBU) || (op == LH) || (op == LHU) || (op == LW);
  endfunction

  function automatic logic is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

endpackage

//--- verilog/load_format.sv
`timescale 1ns/100ps

module load_format import lsu_pkg::*; (
  input  logic [31:0] word_i,
  input  logic [1:0]  off_i,
  input  lsu_op_e     op_i,
  output logic [31:0] rdata_o
);

  logic [31:0] shifted;
  logic [31:0] ext;

  // bring the addressed byte down to lane 0
  assign shifted = word_i >> {off_i, 3'b000};

  always_comb begin
    unique case (op_i)
      LB:      ext = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     ext = {24'h0, shifted[7:0]};
      LH:      ext = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     ext = {16'h0, shifted[15:0]};
      LW:      ext = shifted;
      default: ext = 32'h0;
    endcase
  end

  // stores carry no read data
  assign rdata_o = is_load(op_i) ? ext : 32'h0;

endmodule

//--- verilog/l1d_cache.sv
`timescale 1ns/100ps

module l1d_cache #(
  parameter int          L1D_IDX_W   = 1,
  parameter logic [31:0] CACHE_BASE  = 32'h0000_0000,
  parameter logic [31:0] CACHE_LIMIT = 32'h0000_0800
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        lookup_en_i,
  input  logic [31:0] addr_i,
  output logic        hit_o,
  output logic [31:0] data_o,
  input  logic        fill_en_i,
  input  logic [31:0] fill_data_i,
  input  logic        inv_en_i,
  output logic [31:0] hit_cnt_o,
  output logic [31:0] miss_cnt_o
);

  localparam int LINES = 1 << L1D_IDX_W;
  localparam int TAG_W = 32 - L1D_IDX_W - 2;

  logic [31:0]          data_mem [LINES];
  logic [TAG_W-1:0]     tag_mem  [LINES];
  logic [LINES-1:0]     valid_q;
  logic [31:0]          hit_cnt_q;
  logic [31:0]          miss_cnt_q;

  // address split; bits [1:0] are the byte offset within the word
  logic [TAG_W-1:0]     addr_tag;
  logic [L1D_IDX_W-1:0] addr_idx;
  logic                 in_win;
  logic                 tag_match;

  assign addr_tag  = addr_i[31:L1D_IDX_W+2];
  assign addr_idx  = addr_i[L1D_IDX_W+1:2];
  assign in_win    = (addr_i >= CACHE_BASE) && (addr_i < CACHE_LIMIT);
  assign tag_match = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);

  assign hit_o  = lookup_en_i && in_win && tag_match;
  assign data_o = data_mem[addr_idx];

  // line payload
  always_ff @(posedge clk) begin
    if (fill_en_i && in_win) begin
      data_mem[addr_idx] <= fill_data_i;
      tag_mem[addr_idx]  <= addr_tag;
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (fill_en_i && in_win) begin
      valid_q[addr_idx] <= 1'b1;
    end else if (inv_en_i && tag_match) begin
      valid_q[addr_idx] <= 1'b0;
    end
  end

  // hit and miss statistics where uncached lookups count as misses
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end else if (lookup_en_i) begin
      if (hit_o) begin
        hit_cnt_q <= hit_cnt_q + 32'd1;
      end else begin
        miss_cnt_q <= miss_cnt_q + 32'd1;
      end
    end
  end

  assign hit_cnt_o  = hit_cnt_q;
  assign miss_cnt_o = miss_cnt_q;

  // fill comes from a load, invalidate from a store
  a_fill_inv_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    fill_en_i |-> !inv_en_i);

endmodule

//--- verilog/bus_mem.sv
`timescale 1ns/100ps

module bus_mem import lsu_pkg::*; #(
  parameter int MEM_IDX_W = 10,
  parameter int MEM_LAT   = 3
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        bus_req_i,
  input  bus_req_t    bus_i,
  output logic        bus_ack_o,
  output logic [31:0] bus_rdata_o
);

  localparam int WORDS = 1 << MEM_IDX_W;
  localparam int CNT_W = (MEM_LAT > 1) ? $clog2(MEM_LAT) : 1;

  logic [31:0]          mem [WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic [CNT_W-1:0]     lat_cnt_q;
  logic                 ack_q;
  logic [31:0]          rdata_q;

  assign idx = bus_i.addr[MEM_IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      lat_cnt_q <= '0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= 32'h0;
      end
    end else if (ack_q) begin
      // hold ack until the master drops req
      if (!bus_req_i) begin
        ack_q <= 1'b0;
      end
    end else if (bus_req_i) begin
      if (lat_cnt_q == CNT_W'(MEM_LAT - 1)) begin
        lat_cnt_q <= '0;
        ack_q     <= 1'b1;
        if (bus_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (bus_i.wstrb[b]) begin
              mem[idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
            end
          end
        end else begin
          rdata_q <= mem[idx];
        end
      end else begin
        lat_cnt_q <= lat_cnt_q + 1'b1;
      end
    end
  end

  assign bus_ack_o   = ack_q;
  assign bus_rdata_o = rdata_q;

  // master holds the request through the handshake
  a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    bus_req_i |=> (!bus_req_i || $stable(bus_i)));

endmodule

//--- verilog/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  // core side
  input  logic        req_i,
  input  lsu_req_t    req_data_i,
  output logic        ack_o,
  output lsu_rsp_t    rsp_o,
  // cache side
  output logic        lookup_en_o,
  output logic [31:0] lookup_addr_o,
  input  logic        hit_i,
  input  logic [31:0] hit_data_i,
  output logic        fill_en_o,
  output logic [31:0] fill_data_o,
  output logic        inv_en_o,
  // formatter side
  output logic [31:0] fmt_word_o,
  output logic [1:0]  fmt_off_o,
  output lsu_op_e     fmt_op_o,
  input  logic [31:0] fmt_rdata_i,
  // bus side
  output logic        bus_req_o,
  output bus_req_t    bus_o,
  input  logic        bus_ack_i,
  input  logic [31:0] bus_rdata_i
);

  lsu_state_e  state_q, state_d;
  lsu_req_t    req_q;
  bus_req_t    bus_q;
  logic [31:0] word_q;
  lsu_rsp_t    rsp_q;
  logic        ack_q;
  logic [3:0]  strb_base;

  // next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:     if (req_i) state_d = LOOKUP;
      LOOKUP:   state_d = (is_load(req_q.op) && hit_i) ? RESP : BUS_REQ;
      BUS_REQ:  state_d = BUS_WAIT;
      BUS_WAIT: if (bus_ack_i) state_d = RESP;
      RESP:     state_d = RELEASE;
      RELEASE:  if (!req_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == RESP) begin
        ack_q <= 1'b1;
      end else if (state_q == RELEASE && !req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  // strobe pattern before the lane shift
  always_comb begin
    unique case (req_q.op)
      SB:      strb_base = 4'b0001;
      SH:      strb_base = 4'b0011;
      SW:      strb_base = 4'b1111;
      default: strb_base = 4'b0000;
    endcase
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      req_q <= req_data_i;
    end
    if (state_q == LOOKUP) begin
      word_q <= hit_data_i;
    end
    if (state_q == BUS_WAIT && bus_ack_i) begin
      word_q <= bus_rdata_i;
    end
    if (state_q == BUS_REQ) begin
      bus_q.we    <= is_store(req_q.op);
      bus_q.addr  <= {req_q.addr[31:2], 2'b00};
      bus_q.wdata <= req_q.wdata << {req_q.addr[1:0], 3'b000};
      bus_q.wstrb <= strb_base << req_q.addr[1:0];
    end
    // formatter returns zero for stores
    if (state_q == RESP) begin
      rsp_q.rdata <= fmt_rdata_i;
    end
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

  // one-cycle cache strobes
  assign lookup_en_o   = (state_q == LOOKUP) && is_load(req_q.op);
  assign inv_en_o      = (state_q == LOOKUP) && is_store(req_q.op);
  assign lookup_addr_o = req_q.addr;
  assign fill_en_o     = (state_q == BUS_WAIT) && bus_ack_i && is_load(req_q.op);
  assign fill_data_o   = bus_rdata_i;

  assign fmt_word_o = word_q;
  assign fmt_off_o  = req_q.addr[1:0];
  assign fmt_op_o   = req_q.op;

  assign bus_req_o = (state_q == BUS_WAIT);
  assign bus_o     = bus_q;

  // core must hold the request until ack
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (req_i && !ack_o) |=> (!req_i || $stable(req_data_i)));

  // word-crossing accesses are not supported
  a_no_misalign: assert property (@(posedge clk) disable iff (!rst_n_i)
    (req_i && state_q == IDLE) |->
      !((req_data_i.op inside {LH, LHU, SH}) && req_data_i.addr[1:0] == 2'b11) &&
      !((req_data_i.op inside {LW, SW}) && req_data_i.addr[1:0] != 2'b00));

  // previous bus handshake must be fully closed
  a_bus_four_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(bus_req_o) |-> !bus_ack_i);

endmodule

//--- verilog/lsu_subsys_top.sv
`timescale 1ns/100ps

module lsu_subsys_top import lsu_pkg::*; #(
  parameter int          L1D_IDX_W   = 1,
  parameter logic [31:0] CACHE_BASE  = 32'h0000_0000,
  parameter logic [31:0] CACHE_LIMIT = 32'h0000_0800,
  parameter int          MEM_IDX_W   = 10,
  parameter int          MEM_LAT     = 3
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  lsu_req_t    req_data_i,
  output logic        ack_o,
  output lsu_rsp_t    rsp_o,
  output logic [31:0] hit_cnt_o,
  output logic [31:0] miss_cnt_o
);

  logic        lookup_en;
  logic [31:0] lookup_addr;
  logic        hit;
  logic [31:0] hit_data;
  logic        fill_en;
  logic [31:0] fill_data;
  logic        inv_en;
  logic [31:0] fmt_word;
  logic [1:0]  fmt_off;
  lsu_op_e     fmt_op;
  logic [31:0] fmt_rdata;
  logic        bus_req;
  bus_req_t    bus;
  logic        bus_ack;
  logic [31:0] bus_rdata;

  lsu_ctrl u_ctrl (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .ack_o         (ack_o),
    .rsp_o         (rsp_o),
    .lookup_en_o   (lookup_en),
    .lookup_addr_o (lookup_addr),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .fill_en_o     (fill_en),
    .fill_data_o   (fill_data),
    .inv_en_o      (inv_en),
    .fmt_word_o    (fmt_word),
    .fmt_off_o     (fmt_off),
    .fmt_op_o      (fmt_op),
    .fmt_rdata_i   (fmt_rdata),
    .bus_req_o     (bus_req),
    .bus_o         (bus),
    .bus_ack_i     (bus_ack),
    .bus_rdata_i   (bus_rdata)
  );

  l1d_cache #(
    .L1D_IDX_W   (L1D_IDX_W),
    .CACHE_BASE  (CACHE_BASE),
    .CACHE_LIMIT (CACHE_LIMIT)
  ) u_l1d (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lookup_en_i (lookup_en),
    .addr_i      (lookup_addr),
    .hit_o       (hit),
    .data_o      (hit_data),
    .fill_en_i   (fill_en),
    .fill_data_i (fill_data),
    .inv_en_i    (inv_en),
    .hit_cnt_o   (hit_cnt_o),
    .miss_cnt_o  (miss_cnt_o)
  );

  load_format u_fmt (
    .word_i  (fmt_word),
    .off_i   (fmt_off),
    .op_i    (fmt_op),
    .rdata_o (fmt_rdata)
  );

  // backing store behind the write-through bus
  bus_mem #(
    .MEM_IDX_W (MEM_IDX_W),
    .MEM_LAT   (MEM_LAT)
  ) u_mem (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req),
    .bus_i       (bus),
    .bus_ack_o   (bus_ack),
    .bus_rdata_o (bus_rdata)
  );

endmodule

//--- sim/lsu_tb_vectors.svh
`ifndef LSU_TB_VECTORS_SVH
`define LSU_TB_VECTORS_SVH

// row fields are name, op, byte address, store data, literal expected rdata,
// random store data flag, byte model flag and expected hit flag
task automatic build_table();
  // word with sign bits set in lanes 0 and 3
  add_row("sw_word",     SW,  32'h0000_0100, 32'h8765_43a1, 32'h0, 0, 0, 0);
  add_row("lw_first",    LW,  32'h0000_0100, 32'h0,         32'h0, 0, 1, 0);
  add_row("lb_off0",     LB,  32'h0000_0100, 32'h0,         32'h0, 0, 1, 1);
  add_row("lb_off1",     LB,  32'h0000_0101, 32'h0,         32'h0, 0, 1, 1);
  add_row("lb_off2",     LB,  32'h0000_0102, 32'h0,         32'h0, 0, 1, 1);
  add_row("lb_off3",     LB,  32'h0000_0103, 32'h0,         32'h0, 0, 1, 1);
  add_row("lbu_off0",    LBU, 32'h0000_0100, 32'h0,         32'h0, 0, 1, 1);
  add_row("lbu_off1",    LBU, 32'h0000_0101, 32'h0,         32'h0, 0, 1, 1);
  add_row("lbu_off2",    LBU, 32'h0000_0102, 32'h0,         32'h0, 0, 1, 1);
  add_row("lbu_off3",    LBU, 32'h0000_0103, 32'h0,         32'h0, 0, 1, 1);
  add_row("lh_off0",     LH,  32'h0000_0100, 32'h0,         32'h0, 0, 1, 1);
  add_row("lh_off1",     LH,  32'h0000_0101, 32'h0,         32'h0, 0, 1, 1);
  add_row("lh_off2",     LH,  32'h0000_0102, 32'h0,         32'h0, 0, 1, 1);
  add_row("lhu_off0",    LHU, 32'h0000_0100, 32'h0,         32'h0, 0, 1, 1);
  add_row("lhu_off1",    LHU, 32'h0000_0101, 32'h0,         32'h0, 0, 1, 1);
  add_row("lhu_off2",    LHU, 32'h0000_0102, 32'h0,         32'h0, 0, 1, 1);
  // partial stores into the other line
  add_row("sh_rand",     SH,  32'h0000_0104, 32'h0,         32'h0, 1, 1, 0);
  add_row("sb_lane3",    SB,  32'h0000_0107, 32'h0000_00f0, 32'h0, 0, 1, 0);
  add_row("lw_mixed",    LW,  32'h0000_0104, 32'h0,         32'h0, 0, 1, 0);
  add_row("lh_mixed",    LH,  32'h0000_0104, 32'h0,         32'h0, 0, 1, 1);
  add_row("lb_mixed",    LB,  32'h0000_0107, 32'h0,         32'h0, 0, 1, 1);
  // 0x108 shares index 0 with 0x100
  add_row("sh_off2",     SH,  32'h0000_010a, 32'h0,         32'h0, 1, 1, 0);
  add_row("lw_evict",    LW,  32'h0000_0108, 32'h0,         32'h0, 0, 1, 0);
  add_row("lh_upper",    LH,  32'h0000_010a, 32'h0,         32'h0, 0, 1, 1);
  add_row("lw_refetch",  LW,  32'h0000_0100, 32'h0,         32'h0, 0, 1, 0);
  add_row("lw_again",    LW,  32'h0000_0100, 32'h0,         32'h0, 0, 1, 1);
  // store hits a cached line and drops it
  add_row("sb_inval",    SB,  32'h0000_0102, 32'h0,         32'h0, 1, 1, 0);
  add_row("lw_after_st", LW,  32'h0000_0100, 32'h0,         32'h0, 0, 1, 0);
  add_row("lbu_new",     LBU, 32'h0000_0102, 32'h0,         32'h0, 0, 1, 1);
  // outside the cacheable window so never a hit
  add_row("sw_uncached", SW,  32'h0000_0c00, 32'h1234_5678, 32'h0, 0, 0, 0);
  add_row("lw_unc_a",    LW,  32'h0000_0c00, 32'h0, 32'h1234_5678, 0, 0, 0);
  add_row("lw_unc_b",    LW,  32'h0000_0c00, 32'h0, 32'h1234_5678, 0, 0, 0);
  add_row("lhu_unc",     LHU, 32'h0000_0c02, 32'h0, 32'h0000_1234, 0, 0, 0);
  add_row("lb_unc",      LB,  32'h0000_0c03, 32'h0, 32'h0000_0012, 0, 0, 0);
endtask

`endif

//--- sim/tb_lsu_subsys.sv
`timescale 1ns/100ps

module tb_lsu_subsys import lsu_pkg::*; ();

  localparam int          L1D_IDX_W   = 1;
  localparam logic [31:0] CACHE_BASE  = 32'h0000_0000;
  localparam logic [31:0] CACHE_LIMIT = 32'h0000_0800;
  localparam int          MEM_IDX_W   = 10;
  localparam int          MEM_LAT     = 3;
  localparam int          MEM_BYTES   = 4 << MEM_IDX_W;
  localparam int          MAX_WAIT    = 40;

  // one table row without its name
  typedef struct packed {
    lsu_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic        rnd;
    logic        model;
    logic        exp_hit;
  } vec_t;

  logic        clk;
  logic        rst_n_i;
  logic        req_i;
  lsu_req_t    req_data_i;
  logic        ack_o;
  lsu_rsp_t    rsp_o;
  logic [31:0] hit_cnt_o;
  logic [31:0] miss_cnt_o;

  string       names[$];
  vec_t        vecs[$];
  logic [7:0]  ref_mem [MEM_BYTES];
  int          checks;
  int          mismatches;
  int          timeouts;
  int          exp_hits;
  int          exp_misses;
  int          load_rows;
  bit          stalled;

  lsu_subsys_top #(
    .L1D_IDX_W   (L1D_IDX_W),
    .CACHE_BASE  (CACHE_BASE),
    .CACHE_LIMIT (CACHE_LIMIT),
    .MEM_IDX_W   (MEM_IDX_W),
    .MEM_LAT     (MEM_LAT)
  ) uut (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o),
    .hit_cnt_o  (hit_cnt_o),
    .miss_cnt_o (miss_cnt_o)
  );

  always #10 clk = ~clk;

  task automatic add_row(input string name, input lsu_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] exp,
                         input logic rnd, input logic model, input logic exp_hit);
    vec_t v;
    v.op      = op;
    v.addr    = addr;
    v.wdata   = wdata;
    v.exp     = exp;
    v.rnd     = rnd;
    v.model   = model;
    v.exp_hit = exp_hit;
    names.push_back(name);
    vecs.push_back(v);
  endtask

  `include "lsu_tb_vectors.svh"

  function automatic int access_bytes(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  // little-endian byte model aliased like the bus memory
  function automatic void model_store(lsu_op_e op, logic [31:0] addr, logic [31:0] wdata);
    int n;
    n = access_bytes(op);
    for (int i = 0; i < n; i++) begin
      ref_mem[(addr + i) % MEM_BYTES] = wdata[8*i +: 8];
    end
  endfunction

  function automatic logic [31:0] model_load(lsu_op_e op, logic [31:0] addr);
    logic [31:0] raw;
    int          n;
    raw = 32'h0;
    n   = access_bytes(op);
    for (int i = 0; i < n; i++) begin
      raw[8*i +: 8] = ref_mem[(addr + i) % MEM_BYTES];
    end
    // upper bytes already zero for the unsigned forms
    case (op)
      LB:      return {{24{raw[7]}}, raw[7:0]};
      LH:      return {{16{raw[15]}}, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // samples 1 ns after each rising edge
  task automatic wait_ack(input logic level, input string name, output bit ok);
    int cycles;
    cycles = 0;
    while (ack_o !== level && cycles < MAX_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = (ack_o === level);
    assert (ok) else begin
      timeouts++;
      $display("core handshake stalled: ack_o did not %s within %0d cycles in row %s",
               level ? "rise" : "fall", MAX_WAIT, name);
    end
  endtask

  task automatic run_row(input int k);
    vec_t        v;
    logic [31:0] wdata;
    logic [31:0] exp;
    bit          ok;
    v     = vecs[k];
    wdata = v.rnd ? $urandom : v.wdata;
    @(posedge clk);
    #1;
    req_data_i.op    = v.op;
    req_data_i.addr  = v.addr;
    req_data_i.wdata = wdata;
    req_i            = 1'b1;
    wait_ack(1'b1, names[k], ok);
    if (ok) begin
      if (v.op inside {LB, LBU, LH, LHU, LW}) begin
        exp = v.model ? model_load(v.op, v.addr) : v.exp;
        load_rows++;
        if (v.exp_hit) begin
          exp_hits++;
        end else begin
          exp_misses++;
        end
        check_value(names[k], "rdata", exp, rsp_o.rdata);
      end else begin
        model_store(v.op, v.addr, wdata);
      end
      check_value(names[k], "hit_cnt", exp_hits, hit_cnt_o);
      check_value(names[k], "miss_cnt", exp_misses, miss_cnt_o);
    end
    req_i = 1'b0;
    if (ok) begin
      wait_ack(1'b0, names[k], ok);
    end
    stalled = !ok;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    exp_hits   = 0;
    exp_misses = 0;
    load_rows  = 0;
    stalled    = 1'b0;
    void'($urandom(32'hb60a_02ea));
    for (int a = 0; a < MEM_BYTES; a++) begin
      ref_mem[a] = 8'h00;
    end
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // idle state out of reset
    check_value("reset", "ack", 32'd0, 32'(ack_o));
    check_value("reset", "hit_cnt", 32'd0, hit_cnt_o);
    check_value("reset", "miss_cnt", 32'd0, miss_cnt_o);

    for (int k = 0; k < vecs.size() && !stalled; k++) begin
      run_row(k);
    end

    // each load does exactly one lookup
    check_value("final", "lookups", load_rows, hit_cnt_o + miss_cnt_o);

    $display("summary: %0d checks, %0d mismatches, %0d timeouts",
             checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+sim
verilog/lsu_pkg.sv
verilog/load_format.sv
verilog/l1d_cache.sv
verilog/bus_mem.sv
verilog/lsu_ctrl.sv
verilog/lsu_subsys_top.sv
sim/tb_lsu_subsys.sv
